/* vlog.f */
verilog/lpPkg.sv
verilog/lpCharIf.sv
verilog/lpXlatRam.sv
verilog/lpOpDecode.sv
verilog/lpPrintSeq.sv
verilog/lpColumnCtr.sv
verilog/lp20Printer.sv
bench/lp20PrinterTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP       = lp20PrinterTb
FILELIST  = vlog.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* bench/lp20PrinterTb.sv */
// LP20 character path testbench with printer model, operation table and wrap checks
`default_nettype none
`timescale 1ns/100ps

module lp20PrinterTb
   import lpPkg::*;
   ();

   // Expected printer outcome of one character
   typedef enum logic [1:0] {
      kPrint,
      kPiPrint,
      kUndef,
      kNone
   } expKind_t;

   typedef struct packed {
      logic [2:0] mode;     // {ldDvfu, test, print}
      logic       dHold;
      lpCtrl_t    ctrl;
      logic [7:0] cbuf;
      logic [7:0] ramChr;
      expKind_t   kind;
      logic [7:0] expByte;
   } row_t;

   // Budget per table row and for the wrap run
   localparam int rowCycles   = 64;
   localparam int wrapCycles  = 134 * 32;
   localparam int extraCycles = 200;

   logic       clk;
   logic       rst;
   logic       devReq;
   logic       devAck;
   logic [7:0] cbuf;
   logic       ramWr;
   logic [7:0] ramAddr;
   ramWord_t   ramWdata;
   logic       init;
   logic       cmdGo;
   logic       modeTest;
   logic       modePrint;
   logic       modeLdDvfu;
   logic       testDte;
   logic       testLpe;
   logic       dHold;
   logic       parErr;
   logic       demand = 1'b1;
   logic [7:0] data;
   logic       pi;
   logic       strobe;
   logic       dpar;
   logic       ready;
   logic       setUndc;
   logic       setDte;
   logic       lpe;
   logic       val;
   cctr_t      cctr;

   // Printer model state
   logic [31:0] lcgState = 32'hc7b2add1;
   logic [2:0]  holdLeft = 3'd0;

   // Observed strobes and pulse counts
   logic [7:0] strbData [$];
   logic       strbPi [$];
   int         undcCnt = 0;
   int         dteCnt = 0;
   logic       expVal = 1'b0;

   row_t  rows [$];
   cctr_t expCctr = '0;
   int    expStrbTotal = 0;
   int    timeoutLimit = 0;
   int    cycles = 0;

   lp20Printer lp20Printer_inst (
      .clk        (clk),
      .rst        (rst),
      .devReq     (devReq),
      .devAck     (devAck),
      .cbuf       (cbuf),
      .ramWr      (ramWr),
      .ramAddr    (ramAddr),
      .ramWdata   (ramWdata),
      .init       (init),
      .cmdGo      (cmdGo),
      .modeTest   (modeTest),
      .modePrint  (modePrint),
      .modeLdDvfu (modeLdDvfu),
      .testDte    (testDte),
      .testLpe    (testLpe),
      .dHold      (dHold),
      .parErr     (parErr),
      .demand     (demand),
      .data       (data),
      .pi         (pi),
      .strobe     (strobe),
      .dpar       (dpar),
      .ready      (ready),
      .setUndc    (setUndc),
      .setDte     (setDte),
      .lpe        (lpe),
      .val        (val),
      .cctr       (cctr)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Reporting and compare tasks
   //////////////////////////////////////////////////

   task automatic stopRun();
      $display("Something failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic failWords(input string why);
      $display("%s", why);
      stopRun();
   endtask

   task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
         stopRun();
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         stopRun();
      end
   endtask

   task automatic checkCctr(input string name, input cctr_t got, input cctr_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
         stopRun();
      end
   endtask

   //////////////////////////////////////////////////
   // Printer model and monitor
   //////////////////////////////////////////////////

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Busy for 0 to 7 cycles after every strobe
   always @(posedge clk)
   begin
      if (strobe)
      begin
         lcgState = lcgNext(lcgState);
         holdLeft = lcgState[18:16];
         demand <= (holdLeft == 3'd0);
      end
      else if (holdLeft != 3'd0)
      begin
         holdLeft = holdLeft - 3'd1;
         demand <= (holdLeft == 3'd0);
      end
   end

   // Sampled mid cycle
   always @(negedge clk)
   begin
      if (rst)
      begin
         expVal = 1'b0;
      end
      else
      begin
         checkFlag("val", val, expVal);
         // No new byte offered while the printer is busy
         if (!demand)
         begin
            checkFlag("ready", ready, 1'b0);
         end
         if (strobe)
         begin
            strbData.push_back(data);
            strbPi.push_back(pi);
            // Odd parity over pi and data, testLpe flips it
            checkFlag("dpar", dpar, (($countones({pi, data}) % 2) == 0) != testLpe);
         end
         if (setUndc)
         begin
            undcCnt++;
         end
         if (setDte)
         begin
            dteCnt++;
         end
         if (init || cmdGo)
         begin
            expVal = 1'b0;
         end
         else if (strobe)
         begin
            expVal = ~expVal;
         end
      end
   end

   // Run length limit
   always @(posedge clk)
   begin
      cycles++;
      if ((timeoutLimit != 0) && (cycles > timeoutLimit))
      begin
         failWords("timeout, the run took longer than the test length allows");
      end
   end

   //////////////////////////////////////////////////
   // Expected behavior
   //////////////////////////////////////////////////

   function automatic lpOp_t predictOp(input lpCtrl_t c, input logic hold);
      if ((c >= 4'd12) || (c == 4'd8) || (c == 4'd9))
      begin
         return opRaiseIntr;
      end
      if ((c >= 4'd10) && hold)
      begin
         return opRaiseIntr;
      end
      if ((c <= 4'd1) && !hold)
      begin
         return opPrintCbuf;
      end
      // Even fields translate, odd ones go to the DVFU
      return c[0] ? opPrintDvfu : opPrintRamd;
   endfunction

   function automatic cctr_t nextColumn(input expKind_t k, input logic [7:0] b, input cctr_t cur);
      if (k == kPiPrint)
      begin
         return '0;
      end
      if (k != kPrint)
      begin
         return cur;
      end
      if ((b == asciiCr) || (b == asciiLf) || (b == asciiVt) || (b == asciiFf))
      begin
         return '0;
      end
      if (b == asciiTab)
      begin
         return cur;
      end
      return cur + 8'd1;
   endfunction

   task automatic addRow(input logic [2:0] mode, input logic hold, input lpCtrl_t ctrl,
                         input logic [7:0] cb, input logic [7:0] rc);
      row_t       r;
      lpOp_t      op;
      logic [7:0] sel;
      r.mode   = mode;
      r.dHold  = hold;
      r.ctrl   = ctrl;
      r.cbuf   = cb;
      r.ramChr = rc;
      op = predictOp(ctrl, hold);
      if (mode[2])
      begin
         r.kind    = kPiPrint;
         r.expByte = cb & 8'h7f;
      end
      else if (op == opRaiseIntr)
      begin
         r.kind    = kUndef;
         r.expByte = 8'h00;
      end
      else if (op == opPrintDvfu)
      begin
         r.kind    = kPiPrint;
         r.expByte = rc & 8'h7f;
      end
      else
      begin
         sel       = (op == opPrintCbuf) ? cb : rc;
         r.kind    = (sel == asciiNul) ? kNone : kPrint;
         r.expByte = sel;
      end
      rows.push_back(r);
   endtask

   //////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////

   task automatic waitReady(input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (ready !== level)
      begin
         @(negedge clk);
         n++;
         if (n > 40)
         begin
            failWords("ready did not reach the expected level within 40 cycles");
         end
      end
   endtask

   task automatic waitStrobes(input int want);
      int n;
      n = 0;
      while (strbData.size() < want)
      begin
         @(posedge clk);
         n++;
         if (n > 40)
         begin
            failWords("no printer strobe within 40 cycles");
         end
      end
   endtask

   task automatic waitUndc(input int want);
      int n;
      n = 0;
      while (undcCnt < want)
      begin
         @(posedge clk);
         n++;
         if (n > 40)
         begin
            failWords("no setUndc pulse within 40 cycles");
         end
      end
   endtask

   task automatic loadRam(input logic [7:0] addr, input lpCtrl_t ctrl, input logic [7:0] chr);
      @(posedge clk);
      ramWr         <= 1'b1;
      ramAddr       <= addr;
      ramWdata.ctrl <= ctrl;
      ramWdata.chr  <= chr;
      @(posedge clk);
      ramWr <= 1'b0;
   endtask

   // Write lands on the second edge
   task automatic dmaWrite(input logic [7:0] chr);
      @(posedge clk);
      devReq <= 1'b1;
      devAck <= 1'b1;
      cbuf   <= chr;
      @(posedge clk);
      devReq <= 1'b0;
      devAck <= 1'b0;
   endtask

   task automatic runRow(input row_t r, input logic dteOn, input logic lpeOn);
      int s0;
      int u0;
      int d0;
      int wantStrb;
      @(posedge clk);
      modePrint  <= r.mode[0];
      modeTest   <= r.mode[1];
      modeLdDvfu <= r.mode[2];
      dHold      <= r.dHold;
      testDte    <= dteOn;
      testLpe    <= lpeOn;
      loadRam(r.cbuf, r.ctrl, r.ramChr);
      waitReady(1'b1);
      s0 = strbData.size();
      u0 = undcCnt;
      d0 = dteCnt;
      wantStrb = 0;
      dmaWrite(r.cbuf);
      case (r.kind)
         kPrint,
         kPiPrint:
         begin
            wantStrb = 1;
            waitStrobes(s0 + 1);
            checkByte("data", strbData[s0], r.expByte);
            checkFlag("pi", strbPi[s0], r.kind == kPiPrint);
         end
         kUndef:
            waitUndc(u0 + 1);
         default:
            waitReady(1'b0);
      endcase
      waitReady(1'b1);
      if (strbData.size() != s0 + wantStrb)
      begin
         failWords("wrong number of printer strobes for one character");
      end
      if (undcCnt != u0 + ((r.kind == kUndef) ? 1 : 0))
      begin
         failWords("setUndc pulse count is wrong for one character");
      end
      if (dteCnt != d0 + (dteOn ? 1 : 0))
      begin
         failWords("setDte did not follow testDte for one write");
      end
      expCctr = nextColumn(r.kind, r.expByte, expCctr);
      checkCctr("cctr", cctr, expCctr);
      expStrbTotal += wantStrb;
   endtask

   task automatic sendChar(input logic [7:0] chr, input int n);
      int s0;
      waitReady(1'b1);
      s0 = strbData.size();
      dmaWrite(chr);
      waitStrobes(s0 + n);
      checkByte("data", strbData[s0 + n - 1], chr);
      checkFlag("pi", strbPi[s0 + n - 1], 1'b0);
      expStrbTotal += n;
   endtask

   // Fill a line, then one more char forces LF first
   task automatic runWrap();
      int i;
      int s0;
      loadRam(asciiCr, 4'd0, 8'h00);
      loadRam(8'h58, 4'd0, 8'h00);
      @(posedge clk);
      modePrint  <= 1'b1;
      modeTest   <= 1'b0;
      modeLdDvfu <= 1'b0;
      dHold      <= 1'b0;
      testDte    <= 1'b0;
      sendChar(asciiCr, 1);
      for (i = 0; i < int'(wrapColumn); i++)
      begin
         sendChar(8'h58, 1);
      end
      waitReady(1'b1);
      checkCctr("cctr", cctr, wrapColumn);
      s0 = strbData.size();
      sendChar(8'h58, 2);
      checkByte("data", strbData[s0], asciiLf);
      checkFlag("pi", strbPi[s0], 1'b0);
      waitReady(1'b1);
      checkCctr("cctr", cctr, 8'd1);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      rst        = 1'b1;
      devReq     = 1'b0;
      devAck     = 1'b0;
      cbuf       = '0;
      ramWr      = 1'b0;
      ramAddr    = '0;
      ramWdata   = '0;
      init       = 1'b0;
      cmdGo      = 1'b0;
      modeTest   = 1'b0;
      modePrint  = 1'b0;
      modeLdDvfu = 1'b0;
      testDte    = 1'b0;
      testLpe    = 1'b0;
      dHold      = 1'b0;
      parErr     = 1'b0;

      // Every control field against both dHold levels
      for (int c = 0; c < 16; c++)
      begin
         for (int h = 0; h < 2; h++)
         begin
            addRow(3'b001, h[0], c[3:0], 8'h40 + 8'(c * 2 + h), 8'ha0 + 8'(c * 2 + h));
         end
      end
      // Parser classes, test mode and load DVFU
      addRow(3'b001, 1'b0, 4'd2, 8'h60, asciiNul);
      addRow(3'b001, 1'b0, 4'd0, asciiCr, 8'h00);
      addRow(3'b001, 1'b0, 4'd0, 8'h61, 8'h00);
      addRow(3'b001, 1'b1, 4'd0, 8'h62, asciiTab);
      addRow(3'b001, 1'b0, 4'd2, 8'h63, asciiLf);
      addRow(3'b010, 1'b0, 4'd0, 8'h64, 8'h00);
      addRow(3'b001, 1'b0, 4'd4, 8'h65, asciiVt);
      addRow(3'b010, 1'b0, 4'd6, 8'h66, 8'h7e);
      addRow(3'b001, 1'b0, 4'd0, asciiFf, 8'h00);
      addRow(3'b010, 1'b1, 4'd10, 8'h67, 8'h33);
      addRow(3'b100, 1'b0, 4'd8, 8'hc5, 8'h12);
      addRow(3'b100, 1'b1, 4'd2, 8'hff, 8'h55);

      timeoutLimit = rows.size() * rowCycles + wrapCycles + extraCycles;

      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // Outputs after reset
      @(negedge clk);
      checkFlag("strobe", strobe, 1'b0);
      checkFlag("pi", pi, 1'b0);
      checkByte("data", data, 8'h00);
      checkFlag("setUndc", setUndc, 1'b0);
      checkFlag("val", val, 1'b0);
      checkCctr("cctr", cctr, 8'd0);

      for (int i = 0; i < rows.size(); i++)
      begin
         runRow(rows[i], i[0], i[1]);
      end

      runWrap();

      // Go command clears data valid
      @(posedge clk);
      cmdGo <= 1'b1;
      @(posedge clk);
      cmdGo <= 1'b0;
      @(negedge clk);
      checkFlag("val", val, 1'b0);

      // Parity error masked in test mode
      @(posedge clk);
      parErr   <= 1'b1;
      modeTest <= 1'b0;
      @(negedge clk);
      checkFlag("lpe", lpe, 1'b1);
      @(posedge clk);
      modeTest <= 1'b1;
      @(negedge clk);
      checkFlag("lpe", lpe, 1'b0);
      @(posedge clk);
      parErr <= 1'b0;
      @(negedge clk);

      if (strbData.size() == expStrbTotal)
      begin
         $display("Everything OK");
         $finish;
      end
      else
      begin
         failWords("total strobe count does not match the expected count");
      end
   end

endmodule

`default_nettype wire

/* verilog/lp20Printer.sv */
// LP20 printer character path top level with DMA, RAM load and printer ports
`default_nettype none
`timescale 1ns/100ps

module lp20Printer
   import lpPkg::*;
   (
      input  logic       clk,
      input  logic       rst,
      // DMA character writes
      input  logic       devReq,
      input  logic       devAck,
      input  logic [7:0] cbuf,
      // Host translation RAM load
      input  logic       ramWr,
      input  logic [7:0] ramAddr,
      input  ramWord_t   ramWdata,
      // Control and status levels
      input  logic       init,
      input  logic       cmdGo,
      input  logic       modeTest,
      input  logic       modePrint,
      input  logic       modeLdDvfu,
      input  logic       testDte,
      input  logic       testLpe,
      input  logic       dHold,
      // Printer port
      input  logic       parErr,
      input  logic       demand,
      output logic [7:0] data,
      output logic       pi,
      output logic       strobe,
      output logic       dpar,
      // Status back to the host
      output logic       ready,
      output logic       setUndc,
      output logic       setDte,
      output logic       lpe,
      output logic       val,
      output cctr_t      cctr
   );

   ramWord_t ramd;
   logic     clrCctr;
   logic     incCctr;

   lpCharIf charIf ();

   //////////////////////////////////////////////////
   // Lookup and decode
   //////////////////////////////////////////////////

   // RAM addressed straight from the DMA byte
   lpXlatRam lpXlatRam_inst (
      .clk      (clk),
      .ramWr    (ramWr),
      .ramAddr  (ramAddr),
      .ramWdata (ramWdata),
      .rdAddr   (cbuf),
      .rdData   (ramd)
   );

   lpOpDecode lpOpDecode_inst (
      .clk        (clk),
      .rst        (rst),
      .devReq     (devReq),
      .devAck     (devAck),
      .cbuf       (cbuf),
      .ramd       (ramd),
      .dHold      (dHold),
      .modeLdDvfu (modeLdDvfu),
      .testDte    (testDte),
      .setDte     (setDte),
      .ch         (charIf.dec)
   );

   //////////////////////////////////////////////////
   // Printer side
   //////////////////////////////////////////////////

   lpPrintSeq lpPrintSeq_inst (
      .clk       (clk),
      .rst       (rst),
      .ch        (charIf.seq),
      .modePrint (modePrint),
      .modeTest  (modeTest),
      .demand    (demand),
      .cctr      (cctr),
      .data      (data),
      .pi        (pi),
      .strobe    (strobe),
      .clrCctr   (clrCctr),
      .incCctr   (incCctr),
      .setUndc   (setUndc),
      .ready     (ready)
   );

   lpColumnCtr lpColumnCtr_inst (
      .clk      (clk),
      .rst      (rst),
      .init     (init),
      .cmdGo    (cmdGo),
      .clrCctr  (clrCctr),
      .incCctr  (incCctr),
      .strobe   (strobe),
      .pi       (pi),
      .data     (data),
      .testLpe  (testLpe),
      .modeTest (modeTest),
      .parErr   (parErr),
      .cctr     (cctr),
      .val      (val),
      .dpar     (dpar),
      .lpe      (lpe)
   );

endmodule

`default_nettype wire

/* verilog/lpColumnCtr.sv */
// Column counter with data valid toggle, printer parity and error flags
`default_nettype none
`timescale 1ns/100ps

module lpColumnCtr
   import lpPkg::*;
   (
      input  logic       clk,
      input  logic       rst,
      input  logic       init,
      input  logic       cmdGo,
      input  logic       clrCctr,
      input  logic       incCctr,
      input  logic       strobe,
      input  logic       pi,
      input  logic [7:0] data,
      input  logic       testLpe,
      input  logic       modeTest,
      input  logic       parErr,
      output cctr_t      cctr,
      output logic       val,
      output logic       dpar,
      output logic       lpe
   );

   //////////////////////////////////////////////////
   // Printed columns on the current line
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cctr <= '0;
      end
      else if (clrCctr)
      begin
         cctr <= '0;
      end
      else if (incCctr)
      begin
         cctr <= cctr + 8'd1;
      end
   end

   // Flips per strobe, cleared by init or go
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         val <= 1'b0;
      end
      else if (init || cmdGo)
      begin
         val <= 1'b0;
      end
      else if (strobe)
      begin
         val <= ~val;
      end
   end

   // Odd parity, testLpe forces a bad one
   assign dpar = ~^{testLpe, pi, data};

   // Printer parity errors ignored in test mode
   assign lpe = ~modeTest & parErr;

endmodule

`default_nettype wire

/* verilog/lpPrintSeq.sv */
// Printer port FSM for carriage control, DVFU, null suppression and line wrap
`default_nettype none
`timescale 1ns/100ps

module lpPrintSeq
   import lpPkg::*;
   (
      input  logic       clk,
      input  logic       rst,
      lpCharIf.seq       ch,
      input  logic       modePrint,
      input  logic       modeTest,
      input  logic       demand,
      input  cctr_t      cctr,
      output logic [7:0] data,
      output logic       pi,
      output logic       strobe,
      output logic       clrCctr,
      output logic       incCctr,
      output logic       setUndc,
      output logic       ready
   );

   typedef enum logic [3:0] {
      stIdle,
      stParse,
      stWrapGap,
      stWrapChar,
      stDvfu,
      stWait,
      stSettle1,
      stSettle2,
      stSettle3
   } seqState_t;

   seqState_t  state;
   // Character being worked on
   logic [7:0] pdat;

   //////////////////////////////////////////////////
   // Character latch
   //////////////////////////////////////////////////

   // Only taken from idle, busy arrivals are lost
   always_ff @(posedge clk)
   begin
      if ((state == stIdle) && ch.charStb)
      begin
         if (ch.ldDvfu || (ch.op == opPrintCbuf))
         begin
            pdat <= ch.cbuf;
         end
         else
         begin
            pdat <= ch.xlat;
         end
      end
   end

   //////////////////////////////////////////////////
   // Sequencer
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= stIdle;
         data    <= '0;
         pi      <= 1'b0;
         strobe  <= 1'b0;
         clrCctr <= 1'b0;
         incCctr <= 1'b0;
         setUndc <= 1'b0;
      end
      else
      begin
         // Pulses default low
         strobe  <= 1'b0;
         clrCctr <= 1'b0;
         incCctr <= 1'b0;
         setUndc <= 1'b0;

         case (state)
            stIdle:
               if (ch.charStb)
               begin
                  if (ch.ldDvfu)
                  begin
                     state <= stDvfu;
                  end
                  else if (modePrint || modeTest)
                  begin
                     case (ch.op)
                        opPrintCbuf: state <= stParse;
                        opPrintRamd: state <= stParse;
                        opPrintDvfu: state <= stDvfu;
                        // Undefined char, host is interrupted
                        default:     setUndc <= 1'b1;
                     endcase
                  end
               end

            stParse:
               if (pdat == asciiNul)
               begin
                  // Nulls never reach the printer
                  state <= stWait;
               end
               else if (demand)
               begin
                  pi     <= 1'b0;
                  strobe <= 1'b1;
                  state  <= stWait;
                  case (pdat)
                     // Line terminators
                     asciiCr,
                     asciiLf,
                     asciiVt,
                     asciiFf:
                     begin
                        data    <= pdat;
                        clrCctr <= 1'b1;
                     end
                     // Tabs go out uncounted
                     asciiTab:
                        data <= pdat;
                     default:
                        if (cctr == wrapColumn)
                        begin
                           // Line full so feed first
                           data    <= asciiLf;
                           clrCctr <= 1'b1;
                           state   <= stWrapGap;
                        end
                        else
                        begin
                           data    <= pdat;
                           incCctr <= 1'b1;
                        end
                  endcase
               end

            // Let the printer see the wrap LF
            stWrapGap:
               state <= stWrapChar;

            stWrapChar:
               if (demand)
               begin
                  pi      <= 1'b0;
                  data    <= pdat;
                  strobe  <= 1'b1;
                  incCctr <= 1'b1;
                  state   <= stWait;
               end

            // Vertical format unit command, top bit cleared
            stDvfu:
               if (demand)
               begin
                  pi      <= 1'b1;
                  data    <= {1'b0, pdat[6:0]};
                  strobe  <= 1'b1;
                  clrCctr <= 1'b1;
                  state   <= stWait;
               end

            stWait:
               if (demand)
               begin
                  state <= stSettle1;
               end

            // Printer status settle time
            stSettle1:
               state <= stSettle2;
            stSettle2:
               state <= stSettle3;
            stSettle3:
               state <= stIdle;

            default:
               state <= stIdle;
         endcase
      end
   end

   // DMA may offer the next byte
   assign ready = (state == stIdle) & demand;

endmodule

`default_nettype wire

/* verilog/lpOpDecode.sv */
// DMA write detect, RAM latency alignment and per-character operation lookup
`default_nettype none
`timescale 1ns/100ps

module lpOpDecode
   import lpPkg::*;
   (
      input  logic       clk,
      input  logic       rst,
      input  logic       devReq,
      input  logic       devAck,
      input  logic [7:0] cbuf,
      input  ramWord_t   ramd,
      input  logic       dHold,
      input  logic       modeLdDvfu,
      input  logic       testDte,
      output logic       setDte,
      lpCharIf.dec       ch
   );

   logic       dmaWr;
   logic       dmaWrDly;
   logic [7:0] cbufHeld;
   lpOp_t      op;

   // Write happens on a req/ack edge
   assign dmaWr = devReq & devAck;

   // Delay one clock to line up with the RAM read
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dmaWrDly <= 1'b0;
      end
      else
      begin
         dmaWrDly <= dmaWr;
      end
   end

   // Keep the written byte next to its RAM data
   always_ff @(posedge clk)
   begin
      if (dmaWr)
      begin
         cbufHeld <= cbuf;
      end
   end

   //////////////////////////////////////////////////
   // Operation table, control field and delimiter hold
   //////////////////////////////////////////////////

   always_comb
   begin
      case (ramd.ctrl)
         4'd0:    op = dHold ? opPrintRamd : opPrintCbuf;
         4'd1:    op = dHold ? opPrintDvfu : opPrintCbuf;
         4'd2,
         4'd4,
         4'd6:    op = opPrintRamd;
         4'd3,
         4'd5,
         4'd7:    op = opPrintDvfu;
         // Only valid while no delimiter is held
         4'd10:   op = dHold ? opRaiseIntr : opPrintRamd;
         4'd11:   op = dHold ? opRaiseIntr : opPrintDvfu;
         default: op = opRaiseIntr;
      endcase
   end

   assign ch.charStb = dmaWrDly;
   assign ch.op      = op;
   assign ch.cbuf    = cbufHeld;
   assign ch.xlat    = ramd.chr;
   assign ch.ldDvfu  = modeLdDvfu;

   // Demand timeout test, flagged per write
   assign setDte = dmaWrDly & testDte;

endmodule

`default_nettype wire

/* verilog/lpXlatRam.sv */
// Host-loaded character translation RAM with a registered lookup port
`default_nettype none
`timescale 1ns/100ps

module lpXlatRam
   import lpPkg::*;
   (
      input  logic       clk,
      // Host load side
      input  logic       ramWr,
      input  logic [7:0] ramAddr,
      input  ramWord_t   ramWdata,
      // Character lookup side
      input  logic [7:0] rdAddr,
      output ramWord_t   rdData
   );

   // Storage array
   ramWord_t mem [0:ramDepth-1];

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (ramWr)
      begin
         mem[ramAddr] <= ramWdata;
      end
   end

   //////////////////////////////////////////////////
   // Read port
   //////////////////////////////////////////////////

   // Data appears one clock after the address
   always_ff @(posedge clk)
   begin
      rdData <= mem[rdAddr];
   end

endmodule

`default_nettype wire

/* verilog/lpCharIf.sv */
// Decoded character handoff from the operation decoder to the print sequencer
`default_nettype none
`timescale 1ns/100ps

interface lpCharIf
   import lpPkg::*;
   ();

   // Single-cycle pulse, one per DMA write
   logic       charStb;
   // Fields below only valid with charStb
   lpOp_t      op;
   logic [7:0] cbuf;
   logic [7:0] xlat;
   // Load-DVFU mode level
   logic       ldDvfu;

   modport dec
   (
      output charStb,
      output op,
      output cbuf,
      output xlat,
      output ldDvfu
   );

   modport seq
   (
      input  charStb,
      input  op,
      input  cbuf,
      input  xlat,
      input  ldDvfu
   );

endinterface

`default_nettype wire

/* verilog/lpPkg.sv */
// LP20 character path shared types, operation codes and character constants
`default_nettype none

package lpPkg;

   //////////////////////////////////////////////////
   // Translation RAM layout
   //////////////////////////////////////////////////

   // One entry per possible character code
   localparam int ramDepth = 256;

   // Control bits above the translated character
   localparam int ctrlWidth = 4;
   localparam int charWidth = 8;

   typedef logic [ctrlWidth-1:0] lpCtrl_t;

   // Control field in 11:8, translated character in 7:0
   typedef struct packed {
      lpCtrl_t              ctrl;
      logic [charWidth-1:0] chr;
   } ramWord_t;

   //////////////////////////////////////////////////
   // Per-character operation
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      opPrintCbuf = 2'd0,
      opPrintRamd = 2'd1,
      opPrintDvfu = 2'd2,
      opRaiseIntr = 2'd3
   } lpOp_t;

   // Printed column count
   typedef logic [7:0] cctr_t;

   // Printable char at this column forces a line feed first
   localparam cctr_t wrapColumn = 8'd132;

   //////////////////////////////////////////////////
   // ASCII controls seen by the parser
   //////////////////////////////////////////////////

   localparam logic [7:0] asciiNul = 8'h00;
   localparam logic [7:0] asciiTab = 8'h09;
   localparam logic [7:0] asciiLf  = 8'h0a;
   localparam logic [7:0] asciiVt  = 8'h0b;
   localparam logic [7:0] asciiFf  = 8'h0c;
   localparam logic [7:0] asciiCr  = 8'h0d;

endpackage

`default_nettype wire
